/* cae.f */
logic/cae_pkg.sv
logic/analysis_ctrl.sv
logic/lit_buffer.sv
logic/clause_builder.sv
logic/cae_top.sv
tb/solver_model.sv
tb/cae_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cae_tb
FILELIST  ?= cae.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/cae_tb.sv */
//##############################
// Conflict analysis engine testbench
// Directed First-UIP and handshake tests
//##############################
`timescale 1ns/100ps
`default_nettype none

module cae_tb;
    import cae_pkg::*;

    // Each request finishes in well under 100 cycles, ample margin for seven requests
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk = 1'b0;
    logic reset;
    logic start;
    level_t decision_level;
    logic [LEN_W-1:0] conflict_len;
    lit_entry_t [MAX_LITS-1:0] conflict_lits;
    logic [TRAIL_IDX_W-1:0] trail_height;

    // Memory read ports between DUT and model
    trail_entry_t trail_entry;
    logic [LEN_W-1:0] clause_len;
    lit_t clause_lit;
    level_t level_query_level;
    logic [TRAIL_IDX_W-1:0] trail_idx;
    logic [CLAUSE_ID_W-1:0] clause_id;
    logic [LEN_W-1:0] clause_lit_idx;
    logic [VAR_W-1:0] level_query_var;

    // Learned clause outputs
    logic done;
    logic learned_valid;
    logic [LEN_W-1:0] learned_len;
    lit_t [MAX_LITS-1:0] learned_clause;
    level_t backtrack_level;
    logic unsat;

    int cycle_count = 0;

    cae_top cae_top_inst (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .decision_level    (decision_level),
        .conflict_len      (conflict_len),
        .conflict_lits     (conflict_lits),
        .trail_height      (trail_height),
        .trail_entry       (trail_entry),
        .clause_len        (clause_len),
        .clause_lit        (clause_lit),
        .level_query_level (level_query_level),
        .done              (done),
        .learned_valid     (learned_valid),
        .learned_len       (learned_len),
        .learned_clause    (learned_clause),
        .backtrack_level   (backtrack_level),
        .unsat             (unsat),
        .trail_idx         (trail_idx),
        .clause_id         (clause_id),
        .clause_lit_idx    (clause_lit_idx),
        .level_query_var   (level_query_var)
    );

    solver_model solver_model_inst (
        .trail_idx         (trail_idx),
        .trail_entry       (trail_entry),
        .clause_id         (clause_id),
        .clause_lit_idx    (clause_lit_idx),
        .clause_len        (clause_len),
        .clause_lit        (clause_lit),
        .level_query_var   (level_query_var),
        .level_query_level (level_query_level)
    );

    always #10 clk = ~clk;

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic lit_t make_lit(input logic neg, input int var_n);
        lit_t l;
        l.neg     = neg;
        l.var_idx = VAR_W'(var_n);
        return l;
    endfunction

    function automatic lit_entry_t make_entry(input logic neg, input int var_n, input int lvl);
        lit_entry_t e;
        e.lit   = make_lit(neg, var_n);
        e.level = LEVEL_W'(lvl);
        return e;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Conflict and start go out together, then wait for done
    task automatic start_request(input int lvl, input int len,
                                 input lit_entry_t [MAX_LITS-1:0] lits, input int height);
        @(posedge clk);
        decision_level <= LEVEL_W'(lvl);
        conflict_len   <= LEN_W'(len);
        conflict_lits  <= lits;
        trail_height   <= TRAIL_IDX_W'(height);
        start          <= 1'b1;
        do @(negedge clk); while (!done);
    endtask

    task automatic release_request();
        @(posedge clk);
        start <= 1'b0;
        do @(negedge clk); while (done);
    endtask

    task automatic check_learned(input lit_t [MAX_LITS-1:0] exp_clause, input int exp_len,
                                 input int exp_bt, input logic exp_unsat);
        check("learned_valid", learned_valid, 1'b1);
        check("learned_len", learned_len, exp_len);
        for (int k = 0; k < MAX_LITS; k++)
            check($sformatf("learned_clause[%0d]", k), learned_clause[k], exp_clause[k]);
        check("backtrack_level", backtrack_level, exp_bt);
        check("unsat", unsat, exp_unsat);
    endtask

    // Reset values, done held with start, second request gets a fresh result
    task automatic test_handshake();
        lit_entry_t [MAX_LITS-1:0] conf;
        lit_t [MAX_LITS-1:0] exp_cl;
        @(negedge clk);
        check("done", done, 1'b0);
        check("learned_valid", learned_valid, 1'b0);
        check("unsat", unsat, 1'b0);
        solver_model_inst.clear_all();
        conf    = '0;
        conf[0] = make_entry(1'b0, 10, 5);
        conf[1] = make_entry(1'b1, 11, 2);
        start_request(5, 2, conf, 0);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b0, 10);
        exp_cl[1] = make_lit(1'b1, 11);
        check_learned(exp_cl, 2, 2, 1'b0);
        repeat (4) begin
            @(negedge clk);
            check("done", done, 1'b1);
        end
        release_request();
        conf    = '0;
        conf[0] = make_entry(1'b1, 12, 1);
        start_request(1, 1, conf, 0);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b1, 12);
        check_learned(exp_cl, 1, 0, 1'b0);
        release_request();
    endtask

    // One literal at the current level, only the order changes
    task automatic test_single_uip();
        lit_entry_t [MAX_LITS-1:0] conf;
        lit_t [MAX_LITS-1:0] exp_cl;
        solver_model_inst.clear_all();
        conf    = '0;
        conf[0] = make_entry(1'b1, 1, 1);
        conf[1] = make_entry(1'b0, 2, 3);
        conf[2] = make_entry(1'b1, 3, 2);
        start_request(3, 3, conf, 0);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b0, 2);
        exp_cl[1] = make_lit(1'b1, 1);
        exp_cl[2] = make_lit(1'b1, 3);
        check_learned(exp_cl, 3, 2, 1'b0);
        release_request();
    endtask

    // x5 resolved with (x5 -x4 x7 -x3), -x4 already held
    task automatic test_one_resolution();
        lit_entry_t [MAX_LITS-1:0] conf;
        lit_t [MAX_LITS-1:0] exp_cl;
        solver_model_inst.clear_all();
        solver_model_inst.put_trail(0, 1, 1, NO_REASON);
        solver_model_inst.put_trail(1, 3, 1, NO_REASON);
        solver_model_inst.put_trail(2, 7, 1, NO_REASON);
        solver_model_inst.put_trail(3, 4, 2, NO_REASON);
        solver_model_inst.put_trail(4, 5, 2, 8'd1);
        solver_model_inst.add_clause_lit(1, make_lit(1'b0, 5));
        solver_model_inst.add_clause_lit(1, make_lit(1'b1, 4));
        solver_model_inst.add_clause_lit(1, make_lit(1'b0, 7));
        solver_model_inst.add_clause_lit(1, make_lit(1'b1, 3));
        conf    = '0;
        conf[0] = make_entry(1'b1, 1, 1);
        conf[1] = make_entry(1'b1, 5, 2);
        conf[2] = make_entry(1'b1, 4, 2);
        start_request(2, 3, conf, 5);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b1, 4);
        exp_cl[1] = make_lit(1'b1, 1);
        exp_cl[2] = make_lit(1'b0, 7);
        exp_cl[3] = make_lit(1'b1, 3);
        check_learned(exp_cl, 4, 1, 1'b0);
        release_request();
    endtask

    task automatic test_duplicate_var();
        lit_entry_t [MAX_LITS-1:0] conf;
        lit_t [MAX_LITS-1:0] exp_cl;
        solver_model_inst.clear_all();
        conf    = '0;
        conf[0] = make_entry(1'b0, 6, 4);
        conf[1] = make_entry(1'b1, 2, 1);
        conf[2] = make_entry(1'b0, 6, 4);
        conf[3] = make_entry(1'b0, 9, 3);
        start_request(4, 4, conf, 0);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b0, 6);
        exp_cl[1] = make_lit(1'b1, 2);
        exp_cl[2] = make_lit(1'b0, 9);
        check_learned(exp_cl, 3, 3, 1'b0);
        release_request();
    endtask

    // Root level conflict stops at the decision x2
    task automatic test_root_level();
        lit_entry_t [MAX_LITS-1:0] conf;
        lit_t [MAX_LITS-1:0] exp_cl;
        solver_model_inst.clear_all();
        solver_model_inst.put_trail(0, 1, 0, NO_REASON);
        solver_model_inst.put_trail(1, 2, 0, NO_REASON);
        conf    = '0;
        conf[0] = make_entry(1'b0, 1, 0);
        conf[1] = make_entry(1'b1, 2, 0);
        start_request(0, 2, conf, 2);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b0, 1);
        exp_cl[1] = make_lit(1'b1, 2);
        check_learned(exp_cl, 2, 0, 1'b1);
        release_request();
    endtask

    // x6 then x5 resolved, -x4 left as the first UIP
    task automatic test_two_resolutions();
        lit_entry_t [MAX_LITS-1:0] conf;
        lit_t [MAX_LITS-1:0] exp_cl;
        solver_model_inst.clear_all();
        solver_model_inst.put_trail(0, 1, 1, NO_REASON);
        solver_model_inst.put_trail(1, 2, 2, NO_REASON);
        solver_model_inst.put_trail(2, 3, 3, NO_REASON);
        solver_model_inst.put_trail(3, 4, 3, 8'd2);
        solver_model_inst.put_trail(4, 5, 3, 8'd3);
        solver_model_inst.put_trail(5, 6, 3, 8'd4);
        solver_model_inst.add_clause_lit(2, make_lit(1'b0, 4));
        solver_model_inst.add_clause_lit(2, make_lit(1'b1, 3));
        solver_model_inst.add_clause_lit(3, make_lit(1'b0, 5));
        solver_model_inst.add_clause_lit(3, make_lit(1'b1, 4));
        solver_model_inst.add_clause_lit(3, make_lit(1'b1, 2));
        solver_model_inst.add_clause_lit(4, make_lit(1'b0, 6));
        solver_model_inst.add_clause_lit(4, make_lit(1'b1, 5));
        solver_model_inst.add_clause_lit(4, make_lit(1'b1, 1));
        conf    = '0;
        conf[0] = make_entry(1'b1, 6, 3);
        conf[1] = make_entry(1'b1, 4, 3);
        conf[2] = make_entry(1'b1, 1, 1);
        start_request(3, 3, conf, 6);
        exp_cl    = '0;
        exp_cl[0] = make_lit(1'b1, 4);
        exp_cl[1] = make_lit(1'b1, 1);
        exp_cl[2] = make_lit(1'b1, 2);
        check_learned(exp_cl, 3, 2, 1'b0);
        release_request();
    endtask

    initial begin
        reset          = 1'b1;
        start          = 1'b0;
        decision_level = '0;
        conflict_len   = '0;
        conflict_lits  = '0;
        trail_height   = '0;
        solver_model_inst.clear_all();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_handshake();
        test_single_uip();
        test_one_resolution();
        test_duplicate_var();
        test_root_level();
        test_two_resolutions();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/solver_model.sv */
//##############################
// Solver memory model
// Trail, clause store and level table
//##############################
`timescale 1ns/100ps
`default_nettype none

module solver_model (
    input  logic [cae_pkg::TRAIL_IDX_W-1:0] trail_idx,
    output cae_pkg::trail_entry_t           trail_entry,
    input  logic [cae_pkg::CLAUSE_ID_W-1:0] clause_id,
    input  logic [cae_pkg::LEN_W-1:0]       clause_lit_idx,
    output logic [cae_pkg::LEN_W-1:0]       clause_len,
    output cae_pkg::lit_t                   clause_lit,
    input  logic [cae_pkg::VAR_W-1:0]       level_query_var,
    output cae_pkg::level_t                 level_query_level
);
    import cae_pkg::*;

    localparam int NUM_CLAUSES = 2**CLAUSE_ID_W;

    trail_entry_t trail_mem [2**TRAIL_IDX_W];
    logic [LEN_W-1:0] len_mem [NUM_CLAUSES];
    lit_t lit_mem [NUM_CLAUSES][MAX_LITS];
    level_t level_mem [MAX_VARS+1];

    // All reads answer in the same cycle
    assign trail_entry       = trail_mem[trail_idx];
    assign clause_len        = len_mem[clause_id];
    assign level_query_level = level_mem[level_query_var];

    // Positions past the clause store width read as the null literal
    assign clause_lit = (clause_lit_idx < LEN_W'(MAX_LITS)) ?
                        lit_mem[clause_id][clause_lit_idx[$clog2(MAX_LITS)-1:0]] : '0;

    task automatic clear_all();
        for (int i = 0; i < 2**TRAIL_IDX_W; i++)
            trail_mem[i] = '0;
        for (int c = 0; c < NUM_CLAUSES; c++) begin
            len_mem[c] = '0;
            for (int p = 0; p < MAX_LITS; p++)
                lit_mem[c][p] = '0;
        end
        for (int v = 0; v <= MAX_VARS; v++)
            level_mem[v] = '0;
    endtask

    // Trail push also records the variable's level
    task automatic put_trail(input int idx, input int var_n, input int lvl,
                             input logic [CLAUSE_ID_W-1:0] reason);
        trail_mem[idx] = '{var_idx: VAR_W'(var_n), level: LEVEL_W'(lvl), reason: reason};
        level_mem[var_n] = LEVEL_W'(lvl);
    endtask

    // Appends one literal to a stored clause
    task automatic add_clause_lit(input int id, input lit_t lit);
        lit_mem[id][len_mem[id][$clog2(MAX_LITS)-1:0]] = lit;
        len_mem[id] = len_mem[id] + 1'b1;
    endtask

endmodule

`default_nettype wire

/* logic/cae_top.sv */
//##############################
// Conflict analysis engine top
// First-UIP learning over external trail and clause store
//##############################
`timescale 1ns/100ps
`default_nettype none

module cae_top (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  cae_pkg::level_t                         decision_level,
    input  logic [cae_pkg::LEN_W-1:0]               conflict_len,
    input  cae_pkg::lit_entry_t [cae_pkg::MAX_LITS-1:0] conflict_lits,
    input  logic [cae_pkg::TRAIL_IDX_W-1:0]         trail_height,
    input  cae_pkg::trail_entry_t                   trail_entry,
    input  logic [cae_pkg::LEN_W-1:0]               clause_len,
    input  cae_pkg::lit_t                           clause_lit,
    input  cae_pkg::level_t                         level_query_level,
    output logic                                    done,
    output logic                                    learned_valid,
    output logic [cae_pkg::LEN_W-1:0]               learned_len,
    output cae_pkg::lit_t [cae_pkg::MAX_LITS-1:0]   learned_clause,
    output cae_pkg::level_t                         backtrack_level,
    output logic                                    unsat,
    output logic [cae_pkg::TRAIL_IDX_W-1:0]         trail_idx,
    output logic [cae_pkg::CLAUSE_ID_W-1:0]         clause_id,
    output logic [cae_pkg::LEN_W-1:0]               clause_lit_idx,
    output logic [cae_pkg::VAR_W-1:0]               level_query_var
);
    import cae_pkg::*;

    // Buffer commands from the FSM
    logic load;
    logic append;
    logic invalidate;
    logic finalize;
    lit_t append_lit;
    logic [VAR_W-1:0] resolve_var;

    // Buffer status back to the FSM
    logic [BUF_IDX_W-1:0] cur_count;
    logic trail_hit;

    // Buffer contents seen by the clause builder
    lit_entry_t [BUF_DEPTH-1:0] slots;
    logic [BUF_DEPTH-1:0] slot_valid;
    logic [BUF_IDX_W-1:0] valid_count;

    analysis_ctrl analysis_ctrl_inst (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .conflict_len    (conflict_len),
        .trail_height    (trail_height),
        .trail_entry     (trail_entry),
        .clause_len      (clause_len),
        .clause_lit      (clause_lit),
        .cur_count       (cur_count),
        .trail_hit       (trail_hit),
        .done            (done),
        .load            (load),
        .append          (append),
        .append_lit      (append_lit),
        .invalidate      (invalidate),
        .resolve_var     (resolve_var),
        .finalize        (finalize),
        .trail_idx       (trail_idx),
        .clause_id       (clause_id),
        .clause_lit_idx  (clause_lit_idx),
        .level_query_var (level_query_var)
    );

    // Appended literal level comes straight from the level lookup
    lit_buffer lit_buffer_inst (
        .clk            (clk),
        .reset          (reset),
        .load           (load),
        .conflict_len   (conflict_len),
        .conflict_lits  (conflict_lits),
        .append         (append),
        .append_lit     (append_lit),
        .append_level   (level_query_level),
        .invalidate     (invalidate),
        .resolve_var    (resolve_var),
        .decision_level (decision_level),
        .trail_var      (trail_entry.var_idx),
        .slots          (slots),
        .slot_valid     (slot_valid),
        .valid_count    (valid_count),
        .cur_count      (cur_count),
        .trail_hit      (trail_hit)
    );

    clause_builder clause_builder_inst (
        .clk             (clk),
        .reset           (reset),
        .finalize        (finalize),
        .slots           (slots),
        .slot_valid      (slot_valid),
        .valid_count     (valid_count),
        .decision_level  (decision_level),
        .learned_valid   (learned_valid),
        .learned_len     (learned_len),
        .learned_clause  (learned_clause),
        .backtrack_level (backtrack_level),
        .unsat           (unsat)
    );

endmodule

`default_nettype wire

/* logic/clause_builder.sv */
//##############################
// Learned clause builder
// UIP first, backtrack level, unsat
//##############################
`timescale 1ns/100ps
`default_nettype none

module clause_builder (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         finalize,
    input  cae_pkg::lit_entry_t [cae_pkg::BUF_DEPTH-1:0] slots,
    input  logic [cae_pkg::BUF_DEPTH-1:0]                slot_valid,
    input  logic [cae_pkg::BUF_IDX_W-1:0]                valid_count,
    input  cae_pkg::level_t                              decision_level,
    output logic                                         learned_valid,
    output logic [cae_pkg::LEN_W-1:0]                    learned_len,
    output cae_pkg::lit_t [cae_pkg::MAX_LITS-1:0]        learned_clause,
    output cae_pkg::level_t                              backtrack_level,
    output logic                                         unsat
);
    import cae_pkg::*;

    level_t max_lvl;
    level_t sec_lvl;

    // Packed clause and write position, slot 0 reserved for the UIP
    lit_t [MAX_LITS-1:0] pack;
    logic [LEN_W-1:0] out_n;
    logic uip_found;

    // Highest level, then highest level strictly below it
    always_comb begin
        max_lvl = '0;
        sec_lvl = '0;
        for (int k = 0; k < BUF_DEPTH; k++) begin
            if (slot_valid[k] && slots[k].level > max_lvl)
                max_lvl = slots[k].level;
        end
        for (int k = 0; k < BUF_DEPTH; k++) begin
            if (slot_valid[k] && slots[k].level != max_lvl &&
                slots[k].level > sec_lvl)
                sec_lvl = slots[k].level;
        end
    end

    // First valid slot at max level is the UIP, rest keep slot order
    always_comb begin
        pack      = '0;
        uip_found = 1'b0;
        out_n     = LEN_W'(1);
        for (int k = 0; k < BUF_DEPTH; k++) begin
            if (slot_valid[k]) begin
                if (!uip_found && slots[k].level == max_lvl) begin
                    pack[0]   = slots[k].lit;
                    uip_found = 1'b1;
                end else if (out_n < LEN_W'(MAX_LITS)) begin
                    pack[out_n[$clog2(MAX_LITS)-1:0]] = slots[k].lit;
                    out_n = out_n + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            learned_valid   <= 1'b0;
            learned_len     <= '0;
            backtrack_level <= '0;
            unsat           <= 1'b0;
        end else if (finalize) begin
            learned_valid   <= 1'b1;
            learned_len     <= uip_found ? out_n : '0;
            backtrack_level <= sec_lvl;
            // Empty clause or a root level conflict
            unsat <= (valid_count == '0) || (decision_level == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (finalize)
            learned_clause <= pack;
    end

endmodule

`default_nettype wire

/* logic/lit_buffer.sv */
//##############################
// Literal buffer with seen vector
// Dedup load, append, invalidate, level count
//##############################
`timescale 1ns/100ps
`default_nettype none

module lit_buffer (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        load,
    input  logic [cae_pkg::LEN_W-1:0]                   conflict_len,
    input  cae_pkg::lit_entry_t [cae_pkg::MAX_LITS-1:0] conflict_lits,
    input  logic                                        append,
    input  cae_pkg::lit_t                               append_lit,
    input  cae_pkg::level_t                             append_level,
    input  logic                                        invalidate,
    input  logic [cae_pkg::VAR_W-1:0]                   resolve_var,
    input  cae_pkg::level_t                             decision_level,
    input  logic [cae_pkg::VAR_W-1:0]                   trail_var,
    output cae_pkg::lit_entry_t [cae_pkg::BUF_DEPTH-1:0] slots,
    output logic [cae_pkg::BUF_DEPTH-1:0]               slot_valid,
    output logic [cae_pkg::BUF_IDX_W-1:0]               valid_count,
    output logic [cae_pkg::BUF_IDX_W-1:0]               cur_count,
    output logic                                        trail_hit
);
    import cae_pkg::*;

    // High-water mark, slots are never compacted
    logic [BUF_IDX_W-1:0] fill;
    logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;

    // One bit per variable currently held in a valid slot
    logic [MAX_VARS:0] seen;

    // Deduplicated image of the conflict for a load
    lit_entry_t [BUF_DEPTH-1:0] ld_slots;
    logic [BUF_DEPTH-1:0] ld_valid;
    logic [MAX_VARS:0] ld_seen;
    logic [$clog2(BUF_DEPTH)-1:0] ld_ptr;

    logic add_ok;
    logic [BUF_DEPTH-1:0] at_level;
    logic [BUF_DEPTH-1:0] res_hits;
    logic [BUF_DEPTH-1:0] trail_hits;

    assign wr_ptr = fill[$clog2(BUF_DEPTH)-1:0];

    // Compact the conflict, first occurrence of a variable wins
    always_comb begin
        ld_slots = '0;
        ld_valid = '0;
        ld_seen  = '0;
        ld_ptr   = '0;
        for (int k = 0; k < MAX_LITS; k++) begin
            if (k < int'(conflict_len) &&
                conflict_lits[k].lit.var_idx != '0 &&
                !ld_seen[conflict_lits[k].lit.var_idx]) begin
                ld_slots[ld_ptr] = conflict_lits[k];
                ld_valid[ld_ptr] = 1'b1;
                ld_seen[conflict_lits[k].lit.var_idx] = 1'b1;
                ld_ptr = ld_ptr + 1'b1;
            end
        end
    end

    // Per-slot matches for counting, pivot removal and trail lookup
    always_comb begin
        cur_count = '0;
        for (int k = 0; k < BUF_DEPTH; k++) begin
            at_level[k]   = slot_valid[k] && (slots[k].level == decision_level);
            res_hits[k]   = slot_valid[k] && (slots[k].lit.var_idx == resolve_var);
            trail_hits[k] = at_level[k] && (slots[k].lit.var_idx == trail_var);
            cur_count     = cur_count + BUF_IDX_W'(at_level[k]);
        end
    end

    assign trail_hit = |trail_hits;

    // Literals already held are skipped, full buffer also guards the write
    assign add_ok = append && !seen[append_lit.var_idx] &&
                    (fill < BUF_IDX_W'(BUF_DEPTH));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill        <= '0;
            valid_count <= '0;
            slot_valid  <= '0;
            seen        <= '0;
        end else if (load) begin
            fill        <= BUF_IDX_W'(ld_ptr);
            valid_count <= BUF_IDX_W'(ld_ptr);
            slot_valid  <= ld_valid;
            seen        <= ld_seen;
        end else if (add_ok) begin
            fill                     <= fill + 1'b1;
            valid_count              <= valid_count + 1'b1;
            slot_valid[wr_ptr]       <= 1'b1;
            seen[append_lit.var_idx] <= 1'b1;
        end else if (invalidate) begin
            // Dedup keeps at most one slot per variable
            slot_valid        <= slot_valid & ~res_hits;
            seen[resolve_var] <= 1'b0;
            if (|res_hits)
                valid_count <= valid_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            slots <= ld_slots;
        else if (add_ok)
            slots[wr_ptr] <= '{lit: append_lit, level: append_level};
    end

endmodule

`default_nettype wire

/* logic/analysis_ctrl.sv */
//##############################
// Conflict analysis FSM
// Load, count, trail walk, reason fetch and merge
//##############################
`timescale 1ns/100ps
`default_nettype none

module analysis_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [cae_pkg::LEN_W-1:0]       conflict_len,
    input  logic [cae_pkg::TRAIL_IDX_W-1:0] trail_height,
    input  cae_pkg::trail_entry_t           trail_entry,
    input  logic [cae_pkg::LEN_W-1:0]       clause_len,
    input  cae_pkg::lit_t                   clause_lit,
    input  logic [cae_pkg::BUF_IDX_W-1:0]   cur_count,
    input  logic                            trail_hit,
    output logic                            done,
    output logic                            load,
    output logic                            append,
    output cae_pkg::lit_t                   append_lit,
    output logic                            invalidate,
    output logic [cae_pkg::VAR_W-1:0]       resolve_var,
    output logic                            finalize,
    output logic [cae_pkg::TRAIL_IDX_W-1:0] trail_idx,
    output logic [cae_pkg::CLAUSE_ID_W-1:0] clause_id,
    output logic [cae_pkg::LEN_W-1:0]       clause_lit_idx,
    output logic [cae_pkg::VAR_W-1:0]       level_query_var
);
    import cae_pkg::*;

    cae_state_e state, state_nxt;

    // Trail entries still to visit, current entry sits one below
    logic [TRAIL_IDX_W-1:0] scan_left, scan_left_nxt;

    // Variable being resolved and its reason clause
    logic [VAR_W-1:0] res_var, res_var_nxt;
    logic [CLAUSE_ID_W-1:0] reason_id, reason_id_nxt;
    logic [LEN_W-1:0] reason_len, reason_len_nxt;

    // Reason literal being merged
    logic [LEN_W-1:0] lit_idx, lit_idx_nxt;

    always_comb begin
        state_nxt     = state;
        scan_left_nxt = scan_left;
        res_var_nxt   = res_var;
        reason_id_nxt = reason_id;
        reason_len_nxt = reason_len;
        lit_idx_nxt   = lit_idx;
        load       = 1'b0;
        append     = 1'b0;
        invalidate = 1'b0;
        finalize   = 1'b0;

        case (state)
            IDLE: begin
                // Newest trail entry is visited first
                if (start) begin
                    scan_left_nxt = trail_height;
                    state_nxt     = LOAD;
                end
            end
            LOAD: begin
                load = 1'b1;
                // Empty conflict skips straight to the builder
                state_nxt = (conflict_len == '0) ? FINALIZE : COUNT;
            end
            COUNT: begin
                // One literal left at this level means the UIP is reached
                state_nxt = (cur_count > BUF_IDX_W'(1)) ? FIND : FINALIZE;
            end
            FIND: begin
                if (scan_left == '0) begin
                    // Trail exhausted
                    state_nxt = FINALIZE;
                end else if (trail_hit) begin
                    res_var_nxt = trail_entry.var_idx;
                    state_nxt   = FETCH;
                end else begin
                    scan_left_nxt = scan_left - 1'b1;
                end
            end
            FETCH: begin
                // Trail index unchanged, so same entry still on the port
                reason_id_nxt = trail_entry.reason;
                if (trail_entry.reason == NO_REASON)
                    state_nxt = FINALIZE;
                else
                    state_nxt = READ_LEN;
            end
            READ_LEN: begin
                reason_len_nxt = clause_len;
                lit_idx_nxt    = '0;
                state_nxt      = MERGE;
            end
            MERGE: begin
                if (lit_idx != reason_len) begin
                    // Resolved variable and null literal are never merged
                    append = (clause_lit.var_idx != res_var) &&
                             (clause_lit.var_idx != '0);
                    lit_idx_nxt = lit_idx + 1'b1;
                end else begin
                    // Drop the pivot and move past its trail entry
                    invalidate    = 1'b1;
                    scan_left_nxt = scan_left - 1'b1;
                    state_nxt     = COUNT;
                end
            end
            FINALIZE: begin
                finalize  = 1'b1;
                state_nxt = DONE;
            end
            DONE: begin
                // Hold until the solver releases start
                if (!start)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            scan_left  <= '0;
            res_var    <= '0;
            reason_id  <= '0;
            reason_len <= '0;
            lit_idx    <= '0;
        end else begin
            state      <= state_nxt;
            scan_left  <= scan_left_nxt;
            res_var    <= res_var_nxt;
            reason_id  <= reason_id_nxt;
            reason_len <= reason_len_nxt;
            lit_idx    <= lit_idx_nxt;
        end
    end

    assign done = (state == DONE);

    // Read port addresses, trail index wraps harmlessly at zero
    assign trail_idx       = scan_left - 1'b1;
    assign clause_id       = reason_id;
    assign clause_lit_idx  = lit_idx;
    assign level_query_var = clause_lit.var_idx;

    assign append_lit  = clause_lit;
    assign resolve_var = res_var;

endmodule

`default_nettype wire

/* logic/cae_pkg.sv */
//##############################
// Conflict analysis engine types
// Sizes, literal and trail records, FSM states
//##############################
`default_nettype none

package cae_pkg;

    // Variable index, 0 is never a real variable
    localparam int VAR_W    = 5;
    localparam int MAX_VARS = 31;

    localparam int LEVEL_W  = 8;

    // Conflict and learned clause limits
    localparam int MAX_LITS = 8;
    localparam int LEN_W    = 4;

    // Literal buffer sizing, holds conflict plus merged reasons
    localparam int BUF_DEPTH = 16;
    localparam int BUF_IDX_W = 5;

    localparam int TRAIL_IDX_W = 6;
    localparam int CLAUSE_ID_W = 8;

    // Reason id of a decision variable
    localparam logic [CLAUSE_ID_W-1:0] NO_REASON = '1;

    // Literal word, negation bit on top
    typedef struct packed {
        logic             neg;
        logic [VAR_W-1:0] var_idx;
    } lit_t;

    typedef logic [LEVEL_W-1:0] level_t;

    // Conflict input and buffer slot record
    typedef struct packed {
        lit_t   lit;
        level_t level;
    } lit_entry_t;

    // One trail record as returned by the trail read port
    typedef struct packed {
        logic [VAR_W-1:0]       var_idx;
        level_t                 level;
        logic [CLAUSE_ID_W-1:0] reason;
    } trail_entry_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD,
        COUNT,
        FIND,
        FETCH,
        READ_LEN,
        MERGE,
        FINALIZE,
        DONE
    } cae_state_e;

endpackage

`default_nettype wire
